//--- Bender.yml
package:
  name: connect_four_tt

sources:
  - files:
      - design/c4_game_pkg.sv
      - design/c4_io_pkg.sv
      - design/pwrup_synchronizer.sv
      - design/btn_debounce.sv
      - design/c4_board.sv
      - design/c4_win_check.sv
      - design/debug_controller.sv
      - design/connect_four_tt.sv
  - target: simulation
    files:
      - sim/tb_connect_four_tt.sv

//--- connect_four_tt.f
design/c4_game_pkg.sv
design/c4_io_pkg.sv
design/pwrup_synchronizer.sv
design/btn_debounce.sv
design/c4_board.sv
design/c4_win_check.sv
design/debug_controller.sv
design/connect_four_tt.sv
sim/tb_connect_four_tt.sv

//--- design/btn_debounce.sv
`timescale 1ns/1ps

module btn_debounce #(
  parameter c4_io_pkg::dbc_cnt_t CLKS_TO_WAIT = c4_io_pkg::DEBOUNCE_CYCLES
) (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            e_debug,     // Skip the stable count
  input  c4_io_pkg::btn_t btns_in,
  output c4_io_pkg::btn_t btns_out
);

  logic [c4_io_pkg::N_BUTTONS-1:0] sync_1;
  logic [c4_io_pkg::N_BUTTONS-1:0] sync_2;
  logic [c4_io_pkg::N_BUTTONS-1:0] accepted;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sync_1 <= '0;
      sync_2 <= '0;
    end else begin
      sync_1 <= btns_in;
      sync_2 <= sync_1;
    end
  end

  for (genvar i = 0; i < c4_io_pkg::N_BUTTONS; i++) begin : g_btn
    c4_io_pkg::dbc_cnt_t cnt;
    logic                level;

    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        cnt   <= '0;
        level <= 1'b0;
      end else if (e_debug || sync_2[i] == level) begin
        cnt   <= '0;            // Track directly, nothing pending
        level <= sync_2[i];
      end else if (cnt == CLKS_TO_WAIT) begin
        cnt   <= '0;
        level <= sync_2[i];     // Held long enough
      end else begin
        cnt   <= cnt + 1'b1;
      end
    end

    assign accepted[i] = level;
  end

  assign btns_out = e_debug ? sync_2 : accepted;

endmodule

//--- design/c4_board.sv
`timescale 1ns/1ps

module c4_board (
  input  logic                 clk,
  input  logic                 arst_n,
  input  c4_io_pkg::btn_t      btns,
  input  logic                 check_done,
  input  logic                 win,
  output c4_game_pkg::board_t  board,
  output logic                 check_start,
  output c4_game_pkg::row_t    chk_row,
  output c4_game_pkg::col_t    chk_col,
  output c4_game_pkg::piece_t  chk_piece,
  input  c4_io_pkg::dbg_req_t  dbg_req,
  output c4_game_pkg::piece_t  dbg_piece,
  output c4_io_pkg::status_t   status
);

  c4_game_pkg::game_state_t state;
  c4_io_pkg::btn_t          btns_q;       // Last level, for edge detect
  c4_io_pkg::btn_t          press;
  c4_game_pkg::col_t        cursor;
  c4_game_pkg::piece_t      player;
  c4_game_pkg::winner_t     winner;
  c4_game_pkg::cell_cnt_t   n_placed;
  c4_game_pkg::row_t        drop_row;
  logic                     col_open;
  logic                     board_full;
  logic                     do_drop;

  assign press      = btns & ~btns_q;     // Rising edges only
  assign board_full = (n_placed == c4_game_pkg::cell_cnt_t'(c4_game_pkg::N_CELLS));
  assign do_drop    = (state == c4_game_pkg::READY) && press.drop && col_open;

  // Scan top down so the lowest empty row is kept
  always_comb begin
    col_open = 1'b0;
    drop_row = '0;
    for (int r = c4_game_pkg::N_ROWS - 1; r >= 0; r--) begin
      if (board[r][cursor] == c4_game_pkg::EMPTY) begin
        col_open = 1'b1;
        drop_row = c4_game_pkg::row_t'(r);
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state       <= c4_game_pkg::READY;
      btns_q      <= '0;
      board       <= '0;
      cursor      <= c4_game_pkg::START_COL;
      player      <= c4_game_pkg::P1;
      winner      <= c4_game_pkg::NO_WIN;
      n_placed    <= '0;
      check_start <= 1'b0;
    end else begin
      btns_q      <= btns;                // Edges in CHECK are dropped
      check_start <= 1'b0;
      case (state)
        c4_game_pkg::READY: begin
          if (do_drop) begin
            board[drop_row][cursor] <= player;
            n_placed    <= n_placed + 1'b1;
            check_start <= 1'b1;
            state       <= c4_game_pkg::CHECK;
          end else if (press.right && cursor != c4_game_pkg::col_t'(c4_game_pkg::N_COLS - 1)) begin
            cursor <= cursor + 1'b1;
          end else if (press.left && cursor != '0) begin
            cursor <= cursor - 1'b1;
          end
        end
        c4_game_pkg::CHECK: begin
          if (check_done) begin
            if (win) begin
              winner <= player;
              state  <= c4_game_pkg::OVER;
            end else if (board_full) begin
              winner <= c4_game_pkg::DRAW;
              state  <= c4_game_pkg::OVER;
            end else begin
              player <= (player == c4_game_pkg::P1) ? c4_game_pkg::P2 : c4_game_pkg::P1;
              state  <= c4_game_pkg::READY;
            end
          end
        end
        default: state <= c4_game_pkg::OVER;   // Stuck until reset
      endcase
    end
  end

  // Placed cell handed to the win checker
  always_ff @(posedge clk) begin
    if (do_drop) begin
      chk_row   <= drop_row;
      chk_col   <= cursor;
      chk_piece <= player;
    end
  end

  always_comb begin
    dbg_piece = c4_game_pkg::EMPTY;       // Out of range reads empty
    if (dbg_req.row < c4_game_pkg::N_ROWS && dbg_req.col < c4_game_pkg::N_COLS) begin
      dbg_piece = board[dbg_req.row][dbg_req.col];
    end
  end

  assign status.full        = board_full;
  assign status.player      = player;
  assign status.winner      = winner;
  assign status.current_col = cursor;

endmodule

//--- design/c4_game_pkg.sv
package c4_game_pkg;

  localparam int N_ROWS  = 6;                 // Row 0 is the bottom row
  localparam int N_COLS  = 7;
  localparam int N_CELLS = N_ROWS * N_COLS;
  localparam int WIN_LEN = 4;                 // Pieces in a line to win

  typedef logic [2:0] col_t;
  typedef logic [2:0] row_t;
  typedef logic [5:0] cell_cnt_t;             // Holds 0 to N_CELLS

  localparam col_t START_COL = 3'd3;          // Cursor column after reset

  // Cell contents, also used for the current player
  typedef logic [1:0] piece_t;

  localparam piece_t EMPTY = 2'd0;
  localparam piece_t P1    = 2'd1;
  localparam piece_t P2    = 2'd2;

  // Player codes match piece_t so a winner can be copied from the player
  typedef logic [1:0] winner_t;

  localparam winner_t NO_WIN = 2'd0;
  localparam winner_t DRAW   = 2'd3;          // Board full, no line

  typedef piece_t [N_ROWS-1:0][N_COLS-1:0] board_t;

  typedef enum logic [1:0] {
    READY,                                    // Waiting for a button
    CHECK,                                    // Win check running
    OVER                                      // Held until reset
  } game_state_t;

endpackage

//--- design/c4_io_pkg.sv
package c4_io_pkg;

  localparam int N_BUTTONS = 3;

  typedef logic [21:0] dbc_cnt_t;

  // Stable cycles before a new button level is taken
  localparam dbc_cnt_t DEBOUNCE_CYCLES = 22'h3FFFFF;

  typedef struct packed {
    logic right;
    logic left;
    logic drop;
  } btn_t;

  typedef struct packed {
    c4_game_pkg::row_t row;
    c4_game_pkg::col_t col;
  } dbg_req_t;

  // Field order follows the uo_out bit layout, MSB first
  typedef struct packed {
    logic                 full;
    c4_game_pkg::piece_t  player;
    c4_game_pkg::winner_t winner;
    c4_game_pkg::col_t    current_col;
  } status_t;

endpackage

//--- design/c4_win_check.sv
`timescale 1ns/1ps

module c4_win_check (
  input  logic                clk,
  input  logic                arst_n,
  input  c4_game_pkg::board_t board,
  input  logic                check_start,
  input  c4_game_pkg::row_t   chk_row,
  input  c4_game_pkg::col_t   chk_col,
  input  c4_game_pkg::piece_t chk_piece,
  output logic                check_done,
  output logic                win
);

  typedef enum logic {
    IDLE,
    SCAN
  } chk_state_t;

  chk_state_t          state;
  logic [1:0]          dir;           // 0 horiz, 1 vert, 2 diag, 3 anti-diag
  logic                hit_acc;
  logic                dir_hit;
  c4_game_pkg::row_t   row_q;
  c4_game_pkg::col_t   col_q;
  c4_game_pkg::piece_t piece_q;

  function automatic logic cell_match(input int r, input int c);
    logic in_board;
    in_board = (r >= 0) && (r < c4_game_pkg::N_ROWS) && (c >= 0) && (c < c4_game_pkg::N_COLS);
    return in_board && (board[r][c] == piece_q);
  endfunction

  // Line length through the placed cell in the current direction
  always_comb begin
    int   dr;
    int   dc;
    int   run;
    logic go_pos;
    logic go_neg;
    dr     = (dir == 2'd0) ? 0 : 1;
    dc     = (dir == 2'd1) ? 0 : ((dir == 2'd3) ? -1 : 1);
    run    = 1;
    go_pos = 1'b1;
    go_neg = 1'b1;
    for (int k = 1; k < c4_game_pkg::WIN_LEN; k++) begin
      go_pos = go_pos && cell_match(int'(row_q) + k * dr, int'(col_q) + k * dc);
      go_neg = go_neg && cell_match(int'(row_q) - k * dr, int'(col_q) - k * dc);
      run    = run + int'(go_pos) + int'(go_neg);
    end
    dir_hit = (run >= c4_game_pkg::WIN_LEN);
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= IDLE;
      dir        <= '0;
      hit_acc    <= 1'b0;
      check_done <= 1'b0;
      win        <= 1'b0;
    end else begin
      check_done <= 1'b0;
      case (state)
        IDLE: begin
          if (check_start) begin
            state   <= SCAN;
            dir     <= '0;
            hit_acc <= 1'b0;
          end
        end
        default: begin
          dir     <= dir + 1'b1;
          hit_acc <= hit_acc | dir_hit;
          if (dir == 2'd3) begin          // Last direction done
            state      <= IDLE;
            check_done <= 1'b1;
            win        <= hit_acc | dir_hit;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && check_start) begin
      row_q   <= chk_row;
      col_q   <= chk_col;
      piece_q <= chk_piece;
    end
  end

endmodule

//--- design/connect_four_tt.sv
`timescale 1ns/1ps

module connect_four_tt (
  input  logic [7:0] ui_in,     // Buttons and debug enable
  output logic [7:0] uo_out,    // Game status
  input  logic [7:0] uio_in,    // Debug cell address
  output logic [7:0] uio_out,   // Debug cell contents
  output logic [7:0] uio_oe,
  input  logic       ena,
  input  logic       clk,
  input  logic       rst_n
);

  logic                arst_n;
  logic                e_debug;
  c4_io_pkg::btn_t     btns_raw;
  c4_io_pkg::btn_t     btns;
  c4_io_pkg::status_t  status;
  c4_io_pkg::dbg_req_t dbg_req;
  c4_game_pkg::piece_t dbg_piece;
  c4_game_pkg::board_t board;
  logic                check_start;
  logic                check_done;
  logic                win;
  c4_game_pkg::row_t   chk_row;
  c4_game_pkg::col_t   chk_col;
  c4_game_pkg::piece_t chk_piece;

  assign btns_raw.drop  = ui_in[0];
  assign btns_raw.right = ui_in[1];
  assign btns_raw.left  = ui_in[2];
  assign e_debug        = ui_in[7] & ena;

  assign uo_out = status;               // Struct matches the pin order

  pwrup_synchronizer u_pwrup_sync (
    .clk    (clk),
    .rst_n  (rst_n),
    .arst_n (arst_n)
  );

  btn_debounce u_btn_debounce (
    .clk      (clk),
    .arst_n   (arst_n),
    .e_debug  (e_debug),
    .btns_in  (btns_raw),
    .btns_out (btns)
  );

  c4_board u_board (
    .clk         (clk),
    .arst_n      (arst_n),
    .btns        (btns),
    .check_done  (check_done),
    .win         (win),
    .board       (board),
    .check_start (check_start),
    .chk_row     (chk_row),
    .chk_col     (chk_col),
    .chk_piece   (chk_piece),
    .dbg_req     (dbg_req),
    .dbg_piece   (dbg_piece),
    .status      (status)
  );

  c4_win_check u_win_check (
    .clk         (clk),
    .arst_n      (arst_n),
    .board       (board),
    .check_start (check_start),
    .chk_row     (chk_row),
    .chk_col     (chk_col),
    .chk_piece   (chk_piece),
    .check_done  (check_done),
    .win         (win)
  );

  debug_controller u_debug_ctrl (
    .clk     (clk),
    .arst_n  (arst_n),
    .e_debug (e_debug),
    .uio_in  (uio_in),
    .piece   (dbg_piece),
    .dbg_req (dbg_req),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
  );

endmodule

//--- design/debug_controller.sv
`timescale 1ns/1ps

module debug_controller (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                e_debug,
  input  logic [7:0]          uio_in,
  input  c4_game_pkg::piece_t piece,      // Cell at dbg_req, from the board
  output c4_io_pkg::dbg_req_t dbg_req,
  output logic [7:0]          uio_out,
  output logic [7:0]          uio_oe
);

  c4_game_pkg::piece_t piece_q;

  // Address only follows the pins in debug mode
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dbg_req <= '0;
    end else if (e_debug) begin
      dbg_req.row <= uio_in[2:0];
      dbg_req.col <= uio_in[5:3];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      piece_q <= c4_game_pkg::EMPTY;
    end else if (e_debug) begin
      piece_q <= piece;
    end else begin
      piece_q <= c4_game_pkg::EMPTY;
    end
  end

  assign uio_out = e_debug ? {piece_q, 6'b000000} : 8'h00;
  assign uio_oe  = e_debug ? 8'hC0 : 8'h00;        // Only bits 7:6 drive

endmodule

//--- design/pwrup_synchronizer.sv
`timescale 1ns/1ps

module pwrup_synchronizer (
  input  logic clk,
  input  logic rst_n,     // Raw reset from the pin
  output logic arst_n     // Asserts at once, releases on clk
);

  logic meta;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      meta   <= 1'b0;
      arst_n <= 1'b0;
    end else begin
      meta   <= 1'b1;
      arst_n <= meta;     // Second flop settles release
    end
  end

endmodule

//--- sim/connect_four_trace.txt
# op and args: R|L|D count, G, N (reset), P row col piece, S col winner player full, X
# piece and player: 0 empty, 1 player one, 2 player two; winner 3 means draw
S 3 0 1 0
P 0 0 0
P 5 6 0
P 2 3 0
P 6 7 0
R 6
S 6 0 1 0
L 8
S 0 0 1 0
D 1
S 0 0 2 0
D 5
S 0 0 1 0
P 0 0 1
P 1 0 2
P 4 0 1
P 5 0 2
D 1
S 0 0 1 0
P 5 0 2
R 1
G
S 1 0 1 0
P 0 1 0
# horizontal win for player one
N
D 2
L 1
D 2
L 1
D 2
L 1
D 1
S 0 1 1 0
P 0 0 1
R 1
D 1
S 0 1 1 0
# vertical win for player two
N
D 1
R 1
D 1
R 1
D 1
L 1
D 1
L 2
D 1
R 2
D 1
R 2
D 1
L 2
D 1
S 4 2 2 0
P 3 4 2
# diagonal win for player one
N
L 3
D 1
R 1
D 2
R 1
D 2
R 1
D 1
L 1
D 1
R 1
D 2
R 2
D 1
L 2
D 1
S 3 1 1 0
P 3 3 1
L 1
S 3 1 1 0
X

//--- sim/tb_connect_four_tt.sv
`timescale 1ns/1ps

module tb_connect_four_tt;

  localparam int CLK_HALF    = 10;            // 20 ns period
  localparam int RST_CYCLES  = 3;
  localparam int HOLD_CYCLES = 6;             // Cycles held down and then up
  localparam int STATUS_POLL = 40;
  localparam int PEEK_POLL   = 8;
  localparam int MAX_OPS     = 1000;          // Bound on trace length
  localparam int GLITCH_MAX  = 200;
  localparam int DROP_BIT    = 0;
  localparam int RIGHT_BIT   = 1;
  localparam int LEFT_BIT    = 2;
  localparam int DEBUG_BIT   = 7;

  logic       clk;
  logic       rst_n;
  logic       ena;
  logic [7:0] ui_in;
  logic [7:0] uio_in;
  logic [7:0] uo_out;
  logic [7:0] uio_out;
  logic [7:0] uio_oe;

  connect_four_tt u_dut (
    .ui_in   (ui_in),
    .uo_out  (uo_out),
    .uio_in  (uio_in),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .ena     (ena),
    .clk     (clk),
    .rst_n   (rst_n)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_status(input c4_io_pkg::status_t got, input c4_io_pkg::status_t exp);
    if (got !== exp) begin
      $display("error @%0t: status col %0d winner %0d player %0d full %0b", $time,
               got.current_col, got.winner, got.player, got.full);
      $display("  expected col %0d winner %0d player %0d full %0b",
               exp.current_col, exp.winner, exp.player, exp.full);
      abort_run();
    end
  endtask

  task automatic check_piece(input c4_game_pkg::piece_t got, input c4_game_pkg::piece_t exp,
                             input int row, input int col);
    if (got !== exp) begin
      $display("error @%0t: cell row %0d col %0d holds %0d, expected %0d", $time,
               row, col, got, exp);
      abort_run();
    end
  endtask

  task automatic check_pin_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp) begin
      $display("error @%0t: %s is %02h, expected %02h", $time, what, got, exp);
      abort_run();
    end
  endtask

  // Buttons stay low and debug mode on through reset
  task automatic reset_game();
    @(negedge clk);
    ui_in  = 8'h80;
    uio_in = 8'h00;
    rst_n  = 1'b0;
    repeat (RST_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    repeat (3) @(negedge clk);                // Synchronizer release
  endtask

  task automatic press_button(input int bit_idx, input int count);
    for (int n = 0; n < count; n++) begin
      @(negedge clk);
      ui_in[bit_idx] = 1'b1;
      repeat (HOLD_CYCLES) @(negedge clk);
      ui_in[bit_idx] = 1'b0;
      repeat (HOLD_CYCLES) @(negedge clk);
    end
  endtask

  task automatic expect_status(input c4_io_pkg::status_t exp);
    c4_io_pkg::status_t got;
    got = '0;
    for (int k = 0; k < STATUS_POLL; k++) begin
      @(negedge clk);
      got = c4_io_pkg::status_t'(uo_out);
      if (got === exp) break;
    end
    check_status(got, exp);
  endtask

  task automatic expect_piece(input int row, input int col, input c4_game_pkg::piece_t exp);
    logic [2:0]          row_bits;
    logic [2:0]          col_bits;
    c4_game_pkg::piece_t got;
    row_bits = row[2:0];
    col_bits = col[2:0];
    got      = c4_game_pkg::EMPTY;
    @(negedge clk);
    uio_in = {2'b00, col_bits, row_bits};
    for (int k = 0; k < PEEK_POLL; k++) begin
      @(negedge clk);
      got = uio_out[7:6];
      if (k >= 1 && got === exp) break;       // Valid after two edges
    end
    check_piece(got, exp, row, col);
    check_pin_byte(uio_oe, 8'hC0, "uio_oe");
  endtask

  // Short drop pulse with debug off that the debounce must block
  task automatic glitch_drop();
    int unsigned len;
    len = 1 + ($urandom % GLITCH_MAX);
    @(negedge clk);
    ui_in[DEBUG_BIT] = 1'b0;
    @(negedge clk);
    check_pin_byte(uio_oe, 8'h00, "uio_oe");
    check_pin_byte(uio_out, 8'h00, "uio_out");
    ui_in[DROP_BIT] = 1'b1;
    repeat (len) @(negedge clk);
    ui_in[DROP_BIT] = 1'b0;
    repeat (4) @(negedge clk);                // Let the sync flops clear
    ui_in[DEBUG_BIT] = 1'b1;
  endtask

  initial begin
    int                 fd;
    int                 code;
    int                 n_ops;
    int                 a0;
    int                 a1;
    int                 a2;
    int                 a3;
    byte                op;
    string              skip;
    logic               end_seen;
    c4_io_pkg::status_t exp_status;
    rst_n    = 1'b0;
    ena      = 1'b1;
    ui_in    = 8'h80;
    uio_in   = 8'h00;
    end_seen = 1'b0;
    n_ops    = 0;
    void'($urandom(32'hd99bc690));
    reset_game();
    fd = $fopen("sim/connect_four_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open sim/connect_four_trace.txt");
      abort_run();
    end
    while (!end_seen && n_ops < MAX_OPS) begin
      code = $fscanf(fd, " %c", op);
      if (code != 1) break;
      n_ops++;
      case (op)
        "#": code = $fgets(skip, fd);         // Comment line
        "R": begin
          code = $fscanf(fd, "%d", a0);
          press_button(RIGHT_BIT, a0);
        end
        "L": begin
          code = $fscanf(fd, "%d", a0);
          press_button(LEFT_BIT, a0);
        end
        "D": begin
          code = $fscanf(fd, "%d", a0);
          press_button(DROP_BIT, a0);
        end
        "G": glitch_drop();
        "N": reset_game();
        "P": begin
          code = $fscanf(fd, "%d %d %d", a0, a1, a2);
          expect_piece(a0, a1, c4_game_pkg::piece_t'(a2));
        end
        "S": begin
          code = $fscanf(fd, "%d %d %d %d", a0, a1, a2, a3);
          exp_status.current_col = c4_game_pkg::col_t'(a0);
          exp_status.winner      = c4_game_pkg::winner_t'(a1);
          exp_status.player      = c4_game_pkg::piece_t'(a2);
          exp_status.full        = a3[0];
          expect_status(exp_status);
        end
        "X": end_seen = 1'b1;
        default: begin
          $display("Unknown op '%c' in the trace file", op);
          abort_run();
        end
      endcase
    end
    $fclose(fd);
    if (end_seen) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("The trace file ended without an X line");
      abort_run();
    end
  end

endmodule
